/* filelist.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/ibus_if.sv
hdl/pc_fetch.sv
hdl/jr_stack.sv
hdl/branch_predecode.sv
hdl/instr_fetch.sv
hdl/fetch_top.sv
bench/fetch_props.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: mips_fetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/ibus_if.sv
      - hdl/pc_fetch.sv
      - hdl/jr_stack.sv
      - hdl/branch_predecode.sv
      - hdl/instr_fetch.sv
      - hdl/fetch_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/fetch_props.sv
      - bench/fetch_tb.sv

/* bench/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*; ();

    typedef fetch_data_t [1:0] pair_t;

    localparam int PAIRS = 24;
    localparam int INSTR_PER_TEST = 2 * PAIRS;
    localparam int MAX_LAT = 8;
    localparam int N_TESTS = 6;
    localparam int TIMEOUT_NS = INSTR_PER_TEST * 4 * MAX_LAT * 4 * N_TESTS;

    logic clk, reset, stall, redirect, ibus_req, ibus_addr_ok, ibus_data_ok;
    word_t redirect_pc, ibus_addr;
    logic [63:0] ibus_data;
    logic [1:0] slot_en, slot_taken, slot_adel;
    word_t [1:0] slot_instr, slot_pc, slot_target;

    logic [31:0] lfsr;
    word_t prog_addr [64];
    word_t prog_instr [64];
    int prog_n = 0;
    int acc_cnt = -1;
    int data_cnt = -1;
    word_t mem_addr;
    int errors = 0;
    int pair_count = 0;
    int tests_done = 0;

    // reference model state
    word_t m_pc, m_pending;
    logic m_pending_valid, m_last_taken;
    logic [`JR_ENTRY_WIDTH - 1:0] m_ptr;
    word_t m_stack [`JR_DEPTH];

    fetch_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // unprogrammed words are addiu with a pattern of the whole address
    function automatic word_t mem_word(input word_t a);
        for (int i = prog_n - 1; i >= 0; i--)
            if (prog_addr[i] == a)
                return prog_instr[i];
        return {6'b001001, a[31:6] ^ {20'b0, a[5:0]}};
    endfunction

    function automatic word_t jump_instr(input logic [5:0] op, input word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic add_word(input word_t a, input word_t instr);
        prog_addr[prog_n] = a;
        prog_instr[prog_n] = instr;
        prog_n++;
    endtask

    function automatic bpb_result_t predict(input word_t instr, input word_t pcplus4);
        bpb_result_t p;
        p = '0;
        if (instr[31:26] == `OP_J || instr[31:26] == `OP_JAL)
        begin
            p.taken = 1'b1;
            p.kind = (instr[31:26] == `OP_J) ? jk_j : jk_jal;
            p.destpc = {pcplus4[31:28], instr[25:0], 2'b00};
        end
        else if (instr[31:26] == `OP_SPECIAL && instr[5:0] == `FN_JR && instr[25:21] == 5'd31)
        begin
            p.taken = 1'b1;
            p.kind = jk_jr_ra;
            p.destpc = m_stack[m_ptr];
        end
        else if (instr[31:26] == `OP_BEQ || instr[31:26] == `OP_BNE)
            p.kind = jk_branch;
        return p;
    endfunction

    function automatic pair_t next_fetch(input word_t pc);
        pair_t p;
        p = '0;
        for (int i = 0; i < 2; i++)
        begin
            p[i].pcplus4 = (i == 1 && !pc[2]) ? pc + 32'd8 : pc + 32'd4;
            p[i].instr = mem_word({pc[31:3], 3'b000} + 32'd4 * i);
            p[i].adel = |pc[1:0];
            p[i].pred = predict(p[i].instr, p[i].pcplus4);
        end
        p[0].en = ~pc[2];
        p[1].en = ~m_last_taken;
        return p;
    endfunction

    task automatic update_model(input pair_t p);
        word_t seq;
        logic taken0, taken1;
        seq = m_pc[2] ? m_pc + 32'd4 : m_pc + 32'd8;
        for (int i = 0; i < 2; i++)
        begin
            if (p[i].en && p[i].pred.kind == jk_jal)
            begin
                m_ptr++;
                m_stack[m_ptr] = p[i].pcplus4 + 32'd4;
            end
            else if (p[i].en && p[i].pred.kind == jk_jr_ra)
                m_ptr--;
        end
        taken0 = p[0].en & p[0].pred.taken;
        taken1 = p[1].en & p[1].pred.taken;
        if (m_pending_valid)
        begin
            m_pc = m_pending;
            m_pending_valid = 1'b0;
        end
        else if (taken0)
            m_pc = p[0].pred.destpc;
        else if (taken1)
        begin
            m_pc = seq;
            m_pending = p[1].pred.destpc;
            m_pending_valid = 1'b1;
        end
        else
            m_pc = seq;
        m_last_taken = taken1 & ~taken0;
    endtask

    task automatic check_slot(input string name, input fetch_data_t got, input fetch_data_t exp);
        if (got.en !== exp.en || (exp.en && (got.instr !== exp.instr ||
            got.pred.taken !== exp.pred.taken || got.adel !== exp.adel)))
        begin
            $display("[ERROR] %0t: %s en/instr/taken/adel got %b/%h/%b/%b expected %b/%h/%b/%b",
                     $time, name, got.en, got.instr, got.pred.taken, got.adel,
                     exp.en, exp.instr, exp.pred.taken, exp.adel);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // memory model and random stall
    always @(posedge clk)
    begin
        if (!reset)
        begin
            ibus_addr_ok <= 1'b0;
            ibus_data_ok <= 1'b0;
            stall <= 1'b0;
            acc_cnt = -1;
            data_cnt = -1;
        end
        else
        begin
            ibus_addr_ok <= 1'b0;
            ibus_data_ok <= 1'b0;
            stall <= (rand_bits(2) == 4'd0);
            if (data_cnt == 0)
            begin
                ibus_data_ok <= 1'b1;
                ibus_data <= {mem_word(mem_addr + 32'd4), mem_word(mem_addr)};
                data_cnt = -1;
            end
            else if (data_cnt > 0)
                data_cnt--;
            if (ibus_req && !ibus_addr_ok && data_cnt < 0)
            begin
                if (acc_cnt < 0)
                    acc_cnt = rand_bits(2);
                if (acc_cnt == 0)
                begin
                    ibus_addr_ok <= 1'b1;
                    mem_addr = ibus_addr;
                    data_cnt = rand_bits(2);
                    acc_cnt = -1;
                end
                else
                    acc_cnt--;
            end
        end
    end

    // compare every advancing pair against the model
    always @(posedge clk)
    begin
        pair_t got, exp;
        if (!reset)
        begin
            m_pc = `RESET_PC;
            m_ptr = '0;
            m_pending = '0;
            m_pending_valid = 1'b0;
            m_last_taken = 1'b0;
            for (int i = 0; i < `JR_DEPTH; i++)
                m_stack[i] = '0;
        end
        else if (redirect)
        begin
            m_pc = redirect_pc;
            m_pending_valid = 1'b0;
            m_last_taken = 1'b0;
        end
        else if (slot_en != 2'b00 && !stall)
        begin
            exp = next_fetch(m_pc);
            for (int i = 0; i < 2; i++)
            begin
                got[i] = '0;
                got[i].en = slot_en[i];
                got[i].instr = slot_instr[i];
                got[i].pcplus4 = slot_pc[i] + 32'd4;
                got[i].pred.taken = slot_taken[i];
                got[i].pred.destpc = slot_target[i];
                got[i].adel = slot_adel[i];
                check_slot($sformatf("slot%0d", i), got[i], exp[i]);
                if (exp[i].en)
                    check_pc($sformatf("slot%0d pc+4", i), got[i].pcplus4, exp[i].pcplus4);
                if (exp[i].en && exp[i].pred.taken)
                    check_pc($sformatf("slot%0d target", i),
                             got[i].pred.destpc, exp[i].pred.destpc);
            end
            update_model(exp);
            pair_count++;
        end
    end

    task automatic redirect_to(input word_t pc);
        @(posedge clk);
        redirect <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic run_pairs(input string name);
        int target, start_errors;
        target = pair_count + PAIRS;
        start_errors = errors;
        while (pair_count < target)
            @(negedge clk);
        tests_done++;
        $display("%s: %0d pairs, %0d errors", name, PAIRS, errors - start_errors);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the fetch stage stopped delivering pairs before the tests ended");
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        word_t fk;
        lfsr = 32'h0520_f783;
        clk = 1'b0;
        reset = 1'b0;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        ibus_addr_ok = 1'b0;
        ibus_data_ok = 1'b0;
        ibus_data = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        run_pairs("straight");

        add_word(32'hbfc0_1000, jump_instr(`OP_J, 32'hbfc0_1040));
        add_word(32'hbfc0_1044, jump_instr(`OP_JAL, 32'hbfc0_1080));
        add_word(32'hbfc0_1084, jump_instr(`OP_J, 32'hbfc0_10c4));
        redirect_to(32'hbfc0_1000);
        run_pairs("jumps");

        // ten nested calls, deeper than the return stack
        for (int k = 0; k <= 10; k++)
        begin
            fk = 32'hbfc0_4000 + 32'h100 * k;
            if (k < 10)
            begin
                add_word(fk, jump_instr(`OP_JAL, fk + 32'h100));
                add_word(fk + 32'd8, {`OP_SPECIAL, 5'd31, 15'd0, `FN_JR});
            end
            else
                add_word(fk, {`OP_SPECIAL, 5'd31, 15'd0, `FN_JR});
        end
        redirect_to(32'hbfc0_4000);
        run_pairs("calls");

        redirect_to(32'hbfc0_7000);
        redirect_to(32'hbfc0_8004);
        run_pairs("odd_word");

        redirect_to(32'hbfc0_a002);
        run_pairs("misaligned");

        add_word(32'hbfc0_c000, {`OP_BEQ, 5'd1, 5'd2, 16'h0004});
        add_word(32'hbfc0_c00c, {`OP_BNE, 5'd3, 5'd0, 16'hfff0});
        add_word(32'hbfc0_c010, {`OP_BEQ, 5'd0, 5'd0, 16'h0020});
        redirect_to(32'hbfc0_c000);
        run_pairs("branches");

        $display("%0d tests, %0d pairs checked, %0d errors, %0d assertion failures",
                 tests_done, pair_count, errors, dut.u_props.assert_errors);
        if (errors == 0 && dut.u_props.assert_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/fetch_props.sv */
`timescale 1ns/1ns

module fetch_props import fetch_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        redirect,
    input logic        ibus_req,
    input word_t       ibus_addr,
    input logic        ibus_addr_ok,
    input logic        ibus_data_ok,
    input logic [1:0]  slot_en,
    input word_t [1:0] slot_instr,
    input word_t [1:0] slot_pc,
    input logic [1:0]  slot_taken
);

    logic outstanding;
    int assert_errors = 0;

    always_ff @(posedge clk)
    begin
        if (~reset)
            outstanding <= 1'b0;
        else if (ibus_req & ibus_addr_ok)
            outstanding <= 1'b1;
        else if (ibus_data_ok)
            outstanding <= 1'b0;
    end

    req_held: assert property (@(posedge clk) disable iff (~reset)
        ibus_req & ~ibus_addr_ok |=> ibus_req & $stable(ibus_addr))
    else
    begin
        $error("ibus request dropped or moved before addr_ok");
        assert_errors++;
    end

    data_after_req: assert property (@(posedge clk) disable iff (~reset)
        ibus_data_ok |-> outstanding)
    else
    begin
        $error("data_ok with no request outstanding");
        assert_errors++;
    end

    // a stalled pair stays on the slots
    stall_holds: assert property (@(posedge clk) disable iff (~reset)
        slot_en != 2'b00 && stall && !redirect |=>
            $stable(slot_en) && $stable(slot_instr) && $stable(slot_pc) && $stable(slot_taken))
    else
    begin
        $error("slots changed while stalled");
        assert_errors++;
    end

    // next request only once the pair has left the slots
    no_req_with_slots: assert property (@(posedge clk) disable iff (~reset)
        ibus_req |-> slot_en == 2'b00)
    else
    begin
        $error("ibus request while a pair is still on the slots");
        assert_errors++;
    end

endmodule

bind fetch_top fetch_props u_props (.*);

/* hdl/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  word_t       redirect_pc,
    output logic        ibus_req,
    output word_t       ibus_addr,
    input  logic        ibus_addr_ok,
    input  logic        ibus_data_ok,
    input  logic [63:0] ibus_data,
    output logic [1:0]  slot_en,
    output word_t [1:0] slot_instr,
    output word_t [1:0] slot_pc,
    output logic [1:0]  slot_taken,
    output word_t [1:0] slot_target,
    output logic [1:0]  slot_adel
);

    word_t pc_pcf, pcplus4_pcf, pcplus8_pcf, jrp_destpc;
    logic fetch_adel, finish_instr;
    bpb_result_t next_predict, destpc_predict_sel;
    fetch_data_t [1:0] fetch_data;
    logic [1:0] hit, jrp_push, jrp_pop;
    word_t [1:0] jrp_push_addr;
    logic [`JR_ENTRY_WIDTH - 1:0] jrp_top;

    ibus_if bus ();

    assign ibus_req = bus.req;
    assign ibus_addr = bus.addr;
    assign bus.addr_ok = ibus_addr_ok;
    assign bus.data_ok = ibus_data_ok;
    assign bus.data = ibus_data;

    pc_fetch u_pc_fetch (
        .clk, .reset, .stall, .redirect, .redirect_pc, .finish_instr,
        .next_predict, .destpc_predict_sel,
        .bus         (bus.requester),
        .pc_pcf, .pcplus4_pcf, .pcplus8_pcf, .fetch_adel
    );

    instr_fetch u_instr_fetch (
        .clk, .reset, .stall,
        .flush          (redirect),
        .pc_pcf, .pcplus4_pcf, .pcplus8_pcf,
        .fetch_adel_pcf (fetch_adel),
        .bus            (bus.monitor),
        .fetch_data,
        .hitF           (hit),
        .finish_instr, .next_predict, .destpc_predict_sel,
        .jrp_push, .jrp_pop, .jrp_push_addr, .jrp_top, .jrp_destpc
    );

    jr_stack u_jr_stack (
        .clk, .reset,
        .push      (jrp_push),
        .pop       (jrp_pop),
        .push_addr (jrp_push_addr),
        .top       (jrp_top),
        .dest      (jrp_destpc)
    );

    assign slot_en = hit;
    genvar i;
    generate
        for (i = 0; i < 2; i++)
        begin : g_out
            assign slot_instr[i] = fetch_data[i].instr;
            assign slot_pc[i] = fetch_data[i].pcplus4 - 32'd4;
            assign slot_taken[i] = fetch_data[i].pred.taken;
            assign slot_target[i] = fetch_data[i].pred.destpc;
            assign slot_adel[i] = fetch_data[i].adel;
        end
    endgenerate

endmodule

/* hdl/instr_fetch.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module instr_fetch import fetch_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         flush,
    input  word_t                        pc_pcf,
    input  word_t                        pcplus4_pcf,
    input  word_t                        pcplus8_pcf,
    input  logic                         fetch_adel_pcf,
    ibus_if.monitor                      bus,
    output fetch_data_t [1:0]            fetch_data,
    output logic [1:0]                   hitF,
    output logic                         finish_instr,
    output bpb_result_t                  next_predict,
    output bpb_result_t                  destpc_predict_sel,
    output logic [1:0]                   jrp_push,
    output logic [1:0]                   jrp_pop,
    output word_t [1:0]                  jrp_push_addr,
    input  logic [`JR_ENTRY_WIDTH - 1:0] jrp_top,
    input  word_t                        jrp_destpc
);

    word_t pc, pcplus4, pcplus8;
    logic adel, finish_his, last_taken, advance;
    logic [63:0] data_his, data;
    logic [1:0] raw_push, raw_pop;
    word_t [1:0] instr, slot_pc, slot_pcplus4;
    bpb_result_t [1:0] pred;
    logic [1:0][`JR_ENTRY_WIDTH - 1:0] slot_top;

    assign finish_instr = finish_his | bus.fetch_ok;
    assign advance = finish_instr & ~stall & ~flush;

    // pc stays put while a finished pair is stalled
    always_ff @(posedge clk)
    begin
        if (~stall | ~finish_instr)
        begin
            pc <= pc_pcf;
            pcplus4 <= pcplus4_pcf;
            pcplus8 <= pcplus8_pcf;
            adel <= fetch_adel_pcf;
        end
        if (bus.fetch_ok)
            data_his <= bus.data;
    end

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            finish_his <= 1'b0;
            last_taken <= 1'b0;
        end
        else if (flush)
        begin
            finish_his <= 1'b0;
            last_taken <= 1'b0;
        end
        else if (advance)
        begin
            finish_his <= 1'b0;
            last_taken <= hitF[1] & pred[1].taken & ~destpc_predict_sel.taken;
        end
        else if (bus.fetch_ok)
            finish_his <= 1'b1;
    end

    assign data = bus.fetch_ok ? bus.data : data_his;
    // slot 1 dropped for the delay-slot pair
    assign hitF = {~last_taken, ~pc[2]} & {2{finish_instr}};

    assign instr[0] = data[31:0];
    assign instr[1] = data[63:32];
    assign slot_pc[0] = pc;
    assign slot_pcplus4[0] = pcplus4;
    assign slot_pc[1] = pc[2] ? pc : pcplus4;
    assign slot_pcplus4[1] = pc[2] ? pcplus4 : pcplus8;

    genvar i;
    generate
        for (i = 0; i < 2; i++)
        begin : g_slot
            branch_predecode u_predecode (
                .pc          (slot_pc[i]),
                .pcplus4     (slot_pcplus4[i]),
                .instr       (instr[i]),
                .pred        (pred[i]),
                .push        (raw_push[i]),
                .pop         (raw_pop[i]),
                .push_addr   (jrp_push_addr[i]),
                .jrp_dest    (jrp_destpc),
                .jrp_top_in  (jrp_top),
                .jrp_top_out (slot_top[i])
            );

            assign fetch_data[i].en = hitF[i];
            assign fetch_data[i].instr = instr[i];
            assign fetch_data[i].pcplus4 = slot_pcplus4[i];
            assign fetch_data[i].pred = hitF[i] ? pred[i] : '0;
            assign fetch_data[i].jrtop = slot_top[i];
            assign fetch_data[i].adel = adel;
        end
    endgenerate

    assign destpc_predict_sel = (hitF[0] & pred[0].taken) ? pred[0] : '0;
    assign next_predict = hitF[1] ? pred[1] : (hitF[0] ? pred[0] : '0);

    assign jrp_push = raw_push & hitF & {2{advance}};
    assign jrp_pop = raw_pop & hitF & {2{advance}};

endmodule

/* hdl/branch_predecode.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module branch_predecode import fetch_pkg::*; (
    input  word_t                        pc,
    input  word_t                        pcplus4,
    input  word_t                        instr,
    output bpb_result_t                  pred,
    output logic                         push,
    output logic                         pop,
    output word_t                        push_addr,
    input  word_t                        jrp_dest,
    input  logic [`JR_ENTRY_WIDTH - 1:0] jrp_top_in,
    output logic [`JR_ENTRY_WIDTH - 1:0] jrp_top_out
);

    logic [5:0] opcode, funct;
    logic [4:0] rs;
    jump_kind_e kind;
    word_t jump_target, branch_target;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];

    always_comb
    begin
        case (opcode)
            `OP_J:
                kind = jk_j;
            `OP_JAL:
                kind = jk_jal;
            `OP_BEQ, `OP_BNE:
                kind = jk_branch;
            `OP_SPECIAL:
                kind = (funct == `FN_JR && rs == 5'd31) ? jk_jr_ra : jk_none;
            default:
                kind = jk_none;
        endcase
    end

    // region of the delay slot
    assign jump_target = {pcplus4[31:28], instr[25:0], 2'b00};
    assign branch_target = pcplus4 + {{14{instr[15]}}, instr[15:0], 2'b00};

    always_comb
    begin
        pred.kind = kind;
        pred.taken = (kind == jk_j) || (kind == jk_jal) || (kind == jk_jr_ra);
        if (kind == jk_jr_ra)
            pred.destpc = jrp_dest;
        else if (kind == jk_branch)
            pred.destpc = branch_target;
        else
            pred.destpc = jump_target;
    end

    assign push = (kind == jk_jal);
    assign pop = (kind == jk_jr_ra);
    assign push_addr = pc + 32'd8;
    assign jrp_top_out = jrp_top_in;

endmodule

/* hdl/jr_stack.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module jr_stack import fetch_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [1:0]                   push,
    input  logic [1:0]                   pop,
    input  word_t [1:0]                  push_addr,
    output logic [`JR_ENTRY_WIDTH - 1:0] top,
    output word_t                        dest
);

    word_t entries [`JR_DEPTH];
    logic [`JR_ENTRY_WIDTH - 1:0] ptr, mid, ptr_n, wr_idx0, wr_idx1;

    assign wr_idx0 = ptr + 1'b1;
    assign wr_idx1 = mid + 1'b1;

    // older slot first, pointer wraps so overflow overwrites the oldest
    always_comb
    begin
        mid = ptr;
        if (push[0])
            mid = wr_idx0;
        else if (pop[0])
            mid = ptr - 1'b1;
        ptr_n = mid;
        if (push[1])
            ptr_n = wr_idx1;
        else if (pop[1])
            ptr_n = mid - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (~reset)
            ptr <= '0;
        else
            ptr <= ptr_n;
    end

    always_ff @(posedge clk)
    begin
        if (push[0])
            entries[wr_idx0] <= push_addr[0];
        if (push[1])
            entries[wr_idx1] <= push_addr[1];
    end

    assign top = ptr;
    assign dest = entries[ptr];

endmodule

/* hdl/pc_fetch.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module pc_fetch import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  word_t       redirect_pc,
    input  logic        finish_instr,
    input  bpb_result_t next_predict,
    input  bpb_result_t destpc_predict_sel,
    ibus_if.requester   bus,
    output word_t       pc_pcf,
    output word_t       pcplus4_pcf,
    output word_t       pcplus8_pcf,
    output logic        fetch_adel
);

    pc_state_e state, state_n;
    word_t pc, pc_n, req_addr, req_addr_n, pending, pending_n, seq_pc;
    logic pending_valid, pending_valid_n, drop, drop_n, advance, req;

    assign advance = finish_instr & ~stall;
    // odd-word fetch only yields one instruction
    assign seq_pc = pc[2] ? pc + 32'd4 : pc + 32'd8;

    always_comb
    begin
        state_n = state;
        pc_n = pc;
        req_addr_n = req_addr;
        pending_n = pending;
        pending_valid_n = pending_valid;
        drop_n = drop;
        case (state)
            pc_idle:
            begin
                if (bus.addr_ok)
                    state_n = pc_wait_data;
            end
            pc_wait_data:
            begin
                if (bus.data_ok & drop)
                begin
                    drop_n = 1'b0;
                    state_n = pc_idle;
                    req_addr_n = {pc[31:3], 3'b000};
                end
                else if (bus.data_ok)
                    state_n = pc_hold;
            end
            default:
                state_n = pc_hold;
        endcase
        if (advance & ~redirect)
        begin
            if (pending_valid)
            begin
                pc_n = pending;
                pending_valid_n = 1'b0;
            end
            else if (destpc_predict_sel.taken)
                pc_n = destpc_predict_sel.destpc;
            else if (next_predict.taken)
            begin
                // jump in slot 1, fetch the delay slot first
                pc_n = seq_pc;
                pending_n = next_predict.destpc;
                pending_valid_n = 1'b1;
            end
            else
                pc_n = seq_pc;
            state_n = pc_idle;
            req_addr_n = {pc_n[31:3], 3'b000};
        end
        if (redirect)
        begin
            pc_n = redirect_pc;
            pending_valid_n = 1'b0;
            if (state == pc_idle && !bus.addr_ok)
                drop_n = 1'b1;
            else if (state == pc_idle || (state == pc_wait_data && !bus.data_ok))
            begin
                drop_n = 1'b1;
                state_n = pc_wait_data;
            end
            else
            begin
                drop_n = 1'b0;
                state_n = pc_idle;
                req_addr_n = {redirect_pc[31:3], 3'b000};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            state <= pc_idle;
            pc <= `RESET_PC;
            req_addr <= `RESET_PC & 32'hffff_fff8;
            pending_valid <= 1'b0;
            drop <= 1'b0;
            req <= 1'b0;
        end
        else
        begin
            state <= state_n;
            pc <= pc_n;
            req_addr <= req_addr_n;
            pending_valid <= pending_valid_n;
            drop <= drop_n;
            req <= (state_n == pc_idle);
        end
    end

    always_ff @(posedge clk)
    begin
        pending <= pending_n;
    end

    assign bus.req = req;
    assign bus.addr = req_addr;
    assign bus.fetch_ok = bus.data_ok & (state == pc_wait_data) & ~drop;

    assign pc_pcf = pc;
    assign pcplus4_pcf = pc + 32'd4;
    assign pcplus8_pcf = pc + 32'd8;
    assign fetch_adel = |pc[1:0];

endmodule

/* hdl/ibus_if.sv */
`timescale 1ns/1ns

interface ibus_if import fetch_pkg::*; ();
    logic        req;
    word_t       addr;
    logic        addr_ok;
    logic        data_ok;
    logic [63:0] data;
    // data_ok that belongs to the current PC, stale responses removed
    logic        fetch_ok;

    modport requester (
        output req, addr, fetch_ok,
        input  addr_ok, data_ok
    );

    modport memory (
        input  req, addr,
        output addr_ok, data_ok, data
    );

    modport monitor (
        input fetch_ok, data
    );
endinterface

/* hdl/fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [31:0] word_t;

    // predecode classes
    typedef enum logic [2:0] {
        jk_none,
        jk_branch,
        jk_j,
        jk_jal,
        jk_jr_ra
    } jump_kind_e;

    typedef struct packed {
        logic       taken;
        jump_kind_e kind;
        word_t      destpc;
    } bpb_result_t;

    // one slot handed to decode
    typedef struct packed {
        logic                         en;
        word_t                        instr;
        word_t                        pcplus4;
        bpb_result_t                  pred;
        logic [`JR_ENTRY_WIDTH - 1:0] jrtop;
        logic                         adel;
    } fetch_data_t;

    typedef enum logic [1:0] {
        pc_idle,
        pc_wait_data,
        pc_hold
    } pc_state_e;

endpackage

/* hdl/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

`define JR_DEPTH        8
`define JR_ENTRY_WIDTH  3
`define RESET_PC        32'hbfc0_0000

`define OP_SPECIAL      6'b000000
`define OP_J            6'b000010
`define OP_JAL          6'b000011
`define OP_BEQ          6'b000100
`define OP_BNE          6'b000101
`define FN_JR           6'b001000

`endif
